//--- common/cnn_pkg.sv
package cnn_pkg;

    ////////////////////
    // widths

    parameter int DATA_WIDTH  = 16;  // one pixel or weight
    parameter int KERNEL_TAPS = 9;   // 3x3 window
    parameter int PARA_KERNEL = 4;   // kernels in parallel, also bank depth
    parameter int ACC_WIDTH   = 36;  // 32-bit products plus guard bits for nine terms
    parameter int INDEX_WIDTH = 8;   // window index, FM_DEPTH up to 256
    parameter int SLOT_WIDTH  = $clog2(PARA_KERNEL);

    ////////////////////
    // data types

    typedef logic signed [DATA_WIDTH-1:0] pixel_t;

    // flattened im2col window, also the layout of one kernel
    typedef pixel_t [KERNEL_TAPS-1:0] window_t;

    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    ////////////////////
    // control encodings

    typedef enum logic {
        RUN_FULL,    // windows then kernels
        RUN_FM_ONLY  // windows only, kernels kept from before
    } run_mode_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_FM,
        LOAD_WT,
        RUN
    } loader_state_t;

    ////////////////////
    // bundles

    // single kernel replacement between runs
    typedef struct packed {
        logic [SLOT_WIDTH-1:0] slot;
        window_t               kernel;
    } weight_update_t;

    // one output per window, a dot product per kernel
    typedef struct packed {
        logic [INDEX_WIDTH-1:0]   index;
        acc_t [PARA_KERNEL-1:0]   sums;
    } result_t;

endpackage

//--- loader/data_loader.sv
`timescale 1ns/1ps

module data_loader #(
    parameter int FM_DEPTH = 18
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                init,
    input  cnn_pkg::run_mode_t                  mode,
    input  logic                                load_valid,
    output logic                                load_ready,
    input  cnn_pkg::window_t                    load_data,
    input  logic                                upd_valid,
    output logic                                upd_ready,
    input  cnn_pkg::weight_update_t             upd,
    output logic                                fm_wr_en,
    output logic [$clog2(FM_DEPTH)-1:0]         fm_wr_addr,
    output cnn_pkg::window_t                    fm_wr_data,
    output logic                                wt_wr_en,
    output logic [cnn_pkg::SLOT_WIDTH-1:0]      wt_wr_slot,
    output cnn_pkg::window_t                    wt_wr_data,
    output logic                                start,
    input  logic                                done
);

    localparam int ADDR_W = $clog2(FM_DEPTH);
    localparam int IDX_W  = cnn_pkg::INDEX_WIDTH;

    cnn_pkg::loader_state_t state;
    cnn_pkg::run_mode_t     mode_q;     // latched at init
    logic [IDX_W-1:0]       cnt;        // word counter within a load phase
    logic                   load_xfer;
    logic                   upd_xfer;

    assign load_ready = (state == cnn_pkg::LOAD_FM) || (state == cnn_pkg::LOAD_WT);
    assign upd_ready  = (state == cnn_pkg::IDLE);
    assign load_xfer  = load_valid && load_ready;
    assign upd_xfer   = upd_valid && upd_ready;

    ////////////////////
    // write routing

    assign fm_wr_en   = load_xfer && (state == cnn_pkg::LOAD_FM);
    assign fm_wr_addr = cnt[ADDR_W-1:0];
    assign fm_wr_data = load_data;

    // updates and kernel loads share the weight port, never in the same state
    assign wt_wr_en   = (load_xfer && (state == cnn_pkg::LOAD_WT)) || upd_xfer;
    assign wt_wr_slot = upd_xfer ? upd.slot : cnt[cnn_pkg::SLOT_WIDTH-1:0];
    assign wt_wr_data = upd_xfer ? upd.kernel : load_data;

    ////////////////////
    // sequencing

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= cnn_pkg::IDLE;
            mode_q <= cnn_pkg::RUN_FULL;
            cnt    <= '0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;  // one-cycle pulse
            case (state)
                cnn_pkg::IDLE: begin
                    if (init) begin
                        mode_q <= mode;
                        cnt    <= '0;
                        state  <= cnn_pkg::LOAD_FM;
                    end
                end
                cnn_pkg::LOAD_FM: begin
                    if (load_xfer) begin
                        if (cnt == IDX_W'(FM_DEPTH - 1)) begin
                            cnt <= '0;
                            if (mode_q == cnn_pkg::RUN_FULL) begin
                                state <= cnn_pkg::LOAD_WT;
                            end else begin
                                state <= cnn_pkg::RUN;
                                start <= 1'b1;
                            end
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                cnn_pkg::LOAD_WT: begin
                    if (load_xfer) begin
                        if (cnt == IDX_W'(cnn_pkg::PARA_KERNEL - 1)) begin
                            cnt   <= '0;
                            state <= cnn_pkg::RUN;
                            start <= 1'b1;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                cnn_pkg::RUN: begin
                    if (done) state <= cnn_pkg::IDLE;  // init ignored until here
                end
                default: state <= cnn_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- logic/fm_buffer.sv
`timescale 1ns/1ps

module fm_buffer #(
    parameter int FM_DEPTH = 18
) (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [$clog2(FM_DEPTH)-1:0] wr_addr,
    input  cnn_pkg::window_t            wr_data,
    input  logic                        rd_en,
    input  logic [$clog2(FM_DEPTH)-1:0] rd_addr,
    output cnn_pkg::window_t            rd_data
);

    cnn_pkg::window_t mem [FM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- logic/weight_bank.sv
`timescale 1ns/1ps

module weight_bank (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    wr_en,
    input  logic [cnn_pkg::SLOT_WIDTH-1:0]          wr_slot,
    input  cnn_pkg::window_t                        wr_data,
    output cnn_pkg::window_t [cnn_pkg::PARA_KERNEL-1:0] kernels
);

    ////////////////////
    // kernel registers

    // all slots drive the mac lanes directly, no read cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            kernels <= '0;
        end else if (wr_en) begin
            kernels[wr_slot] <= wr_data;  // one slot per write
        end
    end

endmodule

//--- conv/mac_array.sv
`timescale 1ns/1ps

module mac_array (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        en,
    input  logic                                        in_valid,
    input  cnn_pkg::window_t                            window,
    input  cnn_pkg::window_t [cnn_pkg::PARA_KERNEL-1:0] kernels,
    output logic                                        out_valid,
    output cnn_pkg::acc_t [cnn_pkg::PARA_KERNEL-1:0]    sums
);

    localparam int LANES = cnn_pkg::PARA_KERNEL;
    localparam int TAPS  = cnn_pkg::KERNEL_TAPS;
    localparam int PROD_W = 2 * cnn_pkg::DATA_WIDTH;

    logic signed [PROD_W-1:0] prod [LANES][TAPS];
    cnn_pkg::acc_t            lane_sum [LANES];
    logic                     s1_valid;

    ////////////////////
    // stage one

    always_ff @(posedge clk) begin
        if (en) begin
            for (int k = 0; k < LANES; k++) begin
                for (int t = 0; t < TAPS; t++) begin
                    prod[k][t] <= $signed(window[t]) * $signed(kernels[k][t]);
                end
            end
        end
    end

    ////////////////////
    // stage two

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_sum[k] = '0;
            for (int t = 0; t < TAPS; t++) begin
                lane_sum[k] = lane_sum[k] + prod[k][t];  // sign-extended to ACC_WIDTH
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int k = 0; k < LANES; k++) begin
                sums[k] <= lane_sum[k];
            end
        end
    end

    // valid bits follow the data, hold on stall
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (en) begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

endmodule

//--- conv/conv_engine.sv
`timescale 1ns/1ps

module conv_engine #(
    parameter int FM_DEPTH = 18
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        start,
    output logic                                        fm_rd_en,
    output logic [$clog2(FM_DEPTH)-1:0]                 fm_rd_addr,
    input  cnn_pkg::window_t                            fm_rd_data,
    input  cnn_pkg::window_t [cnn_pkg::PARA_KERNEL-1:0] kernels,
    output logic                                        result_valid,
    input  logic                                        result_ready,
    output cnn_pkg::result_t                            result,
    output logic                                        done
);

    localparam int ADDR_W = $clog2(FM_DEPTH);
    localparam int IDX_W  = cnn_pkg::INDEX_WIDTH;

    logic                   issuing;
    logic [ADDR_W-1:0]      issue_addr;
    logic                   stall;
    logic                   rd_valid;   // fm_rd_data holds a live window
    logic [IDX_W-1:0]       rd_idx;
    logic [IDX_W-1:0]       s1_idx;
    logic [IDX_W-1:0]       s2_idx;
    logic [ADDR_W-1:0]      done_cnt;
    logic                   res_xfer;
    logic                   mac_valid;
    cnn_pkg::acc_t [cnn_pkg::PARA_KERNEL-1:0] mac_sums;

    // output held, so the whole pipe freezes
    assign stall    = result_valid && !result_ready;
    assign res_xfer = result_valid && result_ready;

    ////////////////////
    // issue

    assign fm_rd_en   = issuing && !stall;
    assign fm_rd_addr = issue_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing    <= 1'b0;
            issue_addr <= '0;
        end else if (start) begin
            issuing    <= 1'b1;
            issue_addr <= '0;
        end else if (fm_rd_en) begin
            if (issue_addr == ADDR_W'(FM_DEPTH - 1)) begin
                issuing <= 1'b0;  // last window issued
            end
            issue_addr <= issue_addr + 1'b1;
        end
    end

    ////////////////////
    // index pipeline, tracks buffer read and both mac stages

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else if (!stall) begin
            rd_valid <= fm_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_idx <= IDX_W'(issue_addr);
            s1_idx <= rd_idx;
            s2_idx <= s1_idx;
        end
    end

    mac_array i_mac_array (
        .clk       (clk),
        .rst       (rst),
        .en        (!stall),
        .in_valid  (rd_valid),
        .window    (fm_rd_data),
        .kernels   (kernels),
        .out_valid (mac_valid),
        .sums      (mac_sums)
    );

    // mac stage two doubles as the output register
    assign result_valid = mac_valid;
    assign result.index = s2_idx;
    assign result.sums  = mac_sums;

    ////////////////////
    // completion

    always_ff @(posedge clk) begin
        if (rst) begin
            done_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (res_xfer) begin
                if (done_cnt == ADDR_W'(FM_DEPTH - 1)) begin
                    done_cnt <= '0;
                    done     <= 1'b1;  // pulse after last accepted result
                end else begin
                    done_cnt <= done_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/cnn_tile.sv
`timescale 1ns/1ps

module cnn_tile #(
    parameter int FM_DEPTH = 18
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    init,
    input  cnn_pkg::run_mode_t      mode,
    input  logic                    load_valid,
    output logic                    load_ready,
    input  cnn_pkg::window_t        load_data,
    input  logic                    upd_valid,
    output logic                    upd_ready,
    input  cnn_pkg::weight_update_t upd,
    output logic                    result_valid,
    input  logic                    result_ready,
    output cnn_pkg::result_t        result,
    output logic                    done
);

    localparam int ADDR_W = $clog2(FM_DEPTH);

    logic                                       fm_wr_en;
    logic [ADDR_W-1:0]                          fm_wr_addr;
    cnn_pkg::window_t                           fm_wr_data;
    logic                                       fm_rd_en;
    logic [ADDR_W-1:0]                          fm_rd_addr;
    cnn_pkg::window_t                           fm_rd_data;
    logic                                       wt_wr_en;
    logic [cnn_pkg::SLOT_WIDTH-1:0]             wt_wr_slot;
    cnn_pkg::window_t                           wt_wr_data;
    cnn_pkg::window_t [cnn_pkg::PARA_KERNEL-1:0] kernels;
    logic                                       start;

    data_loader #(.FM_DEPTH(FM_DEPTH)) i_data_loader (
        .clk        (clk),
        .rst        (rst),
        .init       (init),
        .mode       (mode),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_data  (load_data),
        .upd_valid  (upd_valid),
        .upd_ready  (upd_ready),
        .upd        (upd),
        .fm_wr_en   (fm_wr_en),
        .fm_wr_addr (fm_wr_addr),
        .fm_wr_data (fm_wr_data),
        .wt_wr_en   (wt_wr_en),
        .wt_wr_slot (wt_wr_slot),
        .wt_wr_data (wt_wr_data),
        .start      (start),
        .done       (done)
    );

    fm_buffer #(.FM_DEPTH(FM_DEPTH)) i_fm_buffer (
        .clk     (clk),
        .wr_en   (fm_wr_en),
        .wr_addr (fm_wr_addr),
        .wr_data (fm_wr_data),
        .rd_en   (fm_rd_en),
        .rd_addr (fm_rd_addr),
        .rd_data (fm_rd_data)
    );

    weight_bank i_weight_bank (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wt_wr_en),
        .wr_slot (wt_wr_slot),
        .wr_data (wt_wr_data),
        .kernels (kernels)
    );

    conv_engine #(.FM_DEPTH(FM_DEPTH)) i_conv_engine (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .fm_rd_en     (fm_rd_en),
        .fm_rd_addr   (fm_rd_addr),
        .fm_rd_data   (fm_rd_data),
        .kernels      (kernels),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .done         (done)
    );

endmodule

//--- test/cnn_tile_asserts.sv
`timescale 1ns/1ps

module cnn_tile_asserts (
    input logic             clk,
    input logic             rst,
    input logic             load_ready,
    input logic             upd_ready,
    input logic             result_valid,
    input logic             result_ready,
    input cnn_pkg::result_t result,
    input logic             done
);

    int fail_count = 0;  // failed assertions so far

    // stalled output must hold
    assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result))
    else begin
        $error("result changed while valid and not accepted");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (rst) !(load_ready && upd_ready))
    else begin
        $error("load_ready and upd_ready both high");
        fail_count++;
    end

    // done follows the last accepted result
    assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(result_valid && result_ready))
    else begin
        $error("done rose without a result transfer");
        fail_count++;
    end

endmodule

bind cnn_tile cnn_tile_asserts i_asserts (
    .clk          (clk),
    .rst          (rst),
    .load_ready   (load_ready),
    .upd_ready    (upd_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result),
    .done         (done)
);

//--- test/cnn_tile_tb.sv
`timescale 1ns/1ps

module cnn_tile_tb;

    localparam int FM_DEPTH = 18;
    // loads with gaps plus results with stalls per run, then a wide margin
    localparam int RUN_CYCLES = 2 * (FM_DEPTH + cnn_pkg::PARA_KERNEL) + 2 * FM_DEPTH + 20;
    localparam int TIMEOUT_CYCLES = 5 * RUN_CYCLES * 4;

    logic                    clk;
    logic                    rst;
    logic                    init;
    cnn_pkg::run_mode_t      mode;
    logic                    load_valid;
    logic                    load_ready;
    cnn_pkg::window_t        load_data;
    logic                    upd_valid;
    logic                    upd_ready;
    cnn_pkg::weight_update_t upd;
    logic                    result_valid;
    logic                    result_ready;
    cnn_pkg::result_t        result;
    logic                    done;

    cnn_pkg::window_t fm_model [FM_DEPTH];             // windows as loaded
    cnn_pkg::window_t wt_model [cnn_pkg::PARA_KERNEL]; // kernels as the bank should hold them

    integer seed = 32'h7044;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycles = 0;
    int     res_count = 0;
    int     done_count = 0;
    logic   random_ready = 1'b0;
    string  cur_test = "";

    cnn_tile #(.FM_DEPTH(FM_DEPTH)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // reference and compare

    function automatic cnn_pkg::result_t expected_result(input int idx);
        cnn_pkg::result_t r;
        cnn_pkg::acc_t    acc;
        cnn_pkg::pixel_t  p;
        cnn_pkg::pixel_t  w;
        r.index = cnn_pkg::INDEX_WIDTH'(idx);
        for (int k = 0; k < cnn_pkg::PARA_KERNEL; k++) begin
            acc = '0;
            for (int t = 0; t < cnn_pkg::KERNEL_TAPS; t++) begin
                p = fm_model[idx][t];
                w = wt_model[k][t];
                acc = acc + p * w;  // full signed product
            end
            r.sums[k] = acc;
        end
        return r;
    endfunction

    function automatic cnn_pkg::window_t random_window();
        cnn_pkg::window_t w;
        for (int t = 0; t < cnn_pkg::KERNEL_TAPS; t++) begin
            w[t] = $random(seed);
        end
        return w;
    endfunction

    task automatic check_result(input string name, input cnn_pkg::result_t exp,
                                input cnn_pkg::result_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // result and done monitor
    always @(negedge clk) begin
        if (!rst && result_valid && result_ready) begin
            if (res_count < FM_DEPTH) begin
                check_result(cur_test, expected_result(res_count), result);
            end else begin
                $display("ERROR %s: more results than windows in the run", cur_test);
                errors++;
            end
            res_count++;
        end
        if (!rst && done) begin
            done_count++;
            check_count({cur_test, " result count"}, FM_DEPTH, res_count);
        end
    end

    // random back-pressure when enabled
    initial begin
        logic next_ready;
        result_ready = 1'b1;
        forever begin
            @(posedge clk);
            next_ready = random_ready ? (($random(seed) & 1) != 0) : 1'b1;
            #1;
            result_ready = next_ready;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////
    // stimulus

    task automatic load_word(input cnn_pkg::window_t w, input logic gaps);
        if (gaps && (($random(seed) & 1) != 0)) begin
            @(posedge clk);  // idle cycle with valid low
            #1;
        end
        load_valid = 1'b1;
        load_data  = w;
        @(negedge clk);
        while (!load_ready) @(negedge clk);
        @(posedge clk);
        #1;
        load_valid = 1'b0;
    endtask

    task automatic update_kernel(input int slot, input cnn_pkg::window_t k);
        upd_valid   = 1'b1;
        upd.slot    = cnn_pkg::SLOT_WIDTH'(slot);
        upd.kernel  = k;
        @(negedge clk);
        while (!upd_ready) @(negedge clk);
        @(posedge clk);
        #1;
        upd_valid = 1'b0;
        wt_model[slot] = k;
    endtask

    task automatic do_run(input string name, input cnn_pkg::run_mode_t m,
                          input logic gaps, input logic stall, input logic busy);
        int err_before;
        int n;
        err_before   = errors;
        cur_test     = name;
        res_count    = 0;
        done_count   = 0;
        random_ready = stall;
        for (int i = 0; i < FM_DEPTH; i++) fm_model[i] = random_window();
        if (m == cnn_pkg::RUN_FULL) begin
            for (int k = 0; k < cnn_pkg::PARA_KERNEL; k++) wt_model[k] = random_window();
        end
        init = 1'b1;
        mode = m;
        @(posedge clk);
        #1;
        init = 1'b0;
        for (int i = 0; i < FM_DEPTH; i++) load_word(fm_model[i], gaps);
        if (m == cnn_pkg::RUN_FULL) begin
            for (int k = 0; k < cnn_pkg::PARA_KERNEL; k++) load_word(wt_model[k], gaps);
        end
        n = 0;
        do begin
            @(negedge clk);
            if (upd_ready) begin
                $display("ERROR %s: upd_ready is high while a run is active", name);
                errors++;
            end
            n++;
            if (busy && n == 4) begin
                @(posedge clk);
                #1;
                init       = 1'b1;  // should be ignored in RUN
                upd_valid  = 1'b1;
                upd.slot   = 1;
                upd.kernel = random_window();
            end else if (busy && n == 5) begin
                @(posedge clk);
                #1;
                init = 1'b0;
            end else if (busy && n == 8) begin
                @(posedge clk);
                #1;
                upd_valid = 1'b0;
            end
        end while (!done);
        random_ready = 1'b0;
        @(posedge clk);
        #1;
        if (!upd_ready) begin
            $display("ERROR %s: upd_ready did not return high after done", name);
            errors++;
        end
        repeat (5) @(posedge clk);  // a second done would show up here
        #1;
        check_count({name, " done pulses"}, 1, done_count);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("%s: %s, %0d results", name, (errors == err_before) ? "ok" : "FAILED",
                 res_count);
    endtask

    ////////////////////
    // test sequence

    initial begin
        int total;
        rst        = 1'b1;
        init       = 1'b0;
        mode       = cnn_pkg::RUN_FULL;
        load_valid = 1'b0;
        load_data  = '0;
        upd_valid  = 1'b0;
        upd        = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        if (load_ready || !upd_ready || result_valid || done) begin
            $display("ERROR: outputs not in their reset state after reset");
            errors++;
        end

        do_run("full_run", cnn_pkg::RUN_FULL, 1'b0, 1'b0, 1'b0);
        do_run("back_pressure", cnn_pkg::RUN_FULL, 1'b0, 1'b1, 1'b0);
        do_run("load_gaps", cnn_pkg::RUN_FULL, 1'b1, 1'b0, 1'b0);
        update_kernel(2, random_window());
        do_run("kernel_update", cnn_pkg::RUN_FM_ONLY, 1'b0, 1'b0, 1'b0);
        do_run("busy_init", cnn_pkg::RUN_FULL, 1'b0, 1'b1, 1'b1);

        total = errors + i_dut.i_asserts.fail_count;
        $display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, errors, i_dut.i_asserts.fail_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- list.f
common/cnn_pkg.sv
loader/data_loader.sv
logic/fm_buffer.sv
logic/weight_bank.sv
conv/mac_array.sv
conv/conv_engine.sv
logic/cnn_tile.sv
test/cnn_tile_asserts.sv
test/cnn_tile_tb.sv
